// ==== verilog.f ====
logic/riscv_isa_pkg.sv
logic/riscv_pipe_pkg.sv
logic/riscv_pipe_reg.sv
logic/riscv_regfile.sv
logic/riscv_dstage.sv
logic/riscv_estage.sv
logic/riscv_wbstage.sv
logic/riscv_datapath.sv
sim/riscv_datapath_asserts.sv
sim/riscv_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module riscv_datapath_tb -f verilog.f -o riscv_datapath_sim

status=0
./obj_dir/riscv_datapath_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '>>> FAIL' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== sim/riscv_datapath_tb.sv ====
`default_nettype none

module riscv_datapath_tb
  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND      = 200;  // per random phase, four phases
  localparam int N_PRELOAD   = 93;   // lui, slli, addi for x1..x31
  localparam int N_FIXED     = 9;
  localparam int NUM_INST    = N_FIXED + N_PRELOAD + 4 * N_RAND;
  localparam int TIMEOUT_CYC = 4 * NUM_INST + 100;

  logic      clk;
  logic      reset;
  logic      stall;
  logic      inst_valid;
  inst_t     inst;
  rf_write_t wb;

  xlen_t     model_regs [NUM_REGS];
  rf_write_t exp_q [$];     // expected reports in program order
  int        value_errs;
  int        extra_reports;
  int        reports;
  int        cycles;
  logic      timed_out;

  riscv_datapath u_dut (
    .i_riscv_datapath_clk (clk),
    .i_reset              (reset),
    .i_stall              (stall),
    .i_inst_valid         (inst_valid),
    .i_inst               (inst),
    .o_riscv_datapath_wb  (wb)
  );

  bind riscv_datapath riscv_datapath_asserts u_asserts (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_reset              (i_reset),
    .i_stall              (i_stall),
    .i_wb                 (o_riscv_datapath_wb)
  );

  function automatic reg_addr_t pick(input int lo, input int hi);
    return reg_addr_t'($urandom_range(hi, lo));
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic inst_t enc_lui(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic inst_t rand_op(input int lo, input int hi);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'($urandom);
    f7 = 7'h00;
    if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(1, 0) == 1) f7 = 7'h20;
    return enc_r(f7, pick(lo, hi), pick(lo, hi), f3, pick(1, hi));
  endfunction

  function automatic inst_t rand_imm(input int lo, input int hi);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = 3'($urandom);
    imm = 12'($urandom);  // negative about half the time
    if (f3 == F3_SLL) imm = {6'h00, imm[5:0]};
    if (f3 == F3_SRL_SRA) imm = {1'b0, imm[10], 4'h0, imm[5:0]};  // imm[10] is inst[30]
    if ($urandom_range(7, 0) == 0) return enc_lui(20'($urandom), pick(1, hi));
    return enc_i(imm, pick(lo, hi), f3, pick(1, hi));
  endfunction

  // sequential rv64 semantics, one instruction at a time
  function automatic void apply_model(input inst_t ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    rf_write_t  wr;
    opc = ins[6:0];
    f3  = ins[14:12];
    alt = ins[30];
    rd  = ins[11:7];
    a   = model_regs[ins[19:15]];
    b   = {{(XLEN-12){ins[31]}}, ins[31:20]};
    case (opc)
      OPC_OP:     b = model_regs[ins[24:20]];
      OPC_OP_IMM: if (f3 == F3_ADD_SUB) alt = 1'b0;  // there is no subi
      OPC_LUI: begin
        a   = '0;
        b   = {{(XLEN-32){ins[31]}}, ins[31:12], 12'h000};
        f3  = F3_ADD_SUB;
        alt = 1'b0;
      end
      default: return;  // not an integer op
    endcase
    if (rd == '0) return;
    case (f3)
      F3_ADD_SUB: res = alt ? a - b : a + b;
      F3_SLL:     res = a << b[SHAMT_W-1:0];
      F3_SLT:     res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      F3_SLTU:    res = (a < b) ? 64'd1 : 64'd0;
      F3_XOR:     res = a ^ b;
      F3_SRL_SRA: res = alt ? xlen_t'($signed(a) >>> b[SHAMT_W-1:0]) : a >> b[SHAMT_W-1:0];
      F3_OR:      res = a | b;
      default:    res = a & b;
    endcase
    model_regs[rd] = res;
    wr.we   = 1'b1;
    wr.addr = rd;
    wr.data = res;
    exp_q.push_back(wr);
  endfunction

  task automatic check_wb(input rf_write_t got, input rf_write_t exp);
    if (got.addr !== exp.addr) begin
      value_errs++;
      $display("FAILED o_riscv_datapath_wb.addr: got %h, expected %h", got.addr, exp.addr);
    end
    if (got.data !== exp.data) begin
      value_errs++;
      $display("FAILED o_riscv_datapath_wb.data: got %h, expected %h", got.data, exp.data);
    end
  endtask

  // holds the instruction until an edge without stall takes it
  task automatic issue(input inst_t ins, input int stall_pct);
    logic hold;
    do begin
      hold = ($urandom_range(99, 0) < stall_pct);
      stall      <= hold;
      inst_valid <= 1'b1;
      inst       <= ins;
      @(posedge clk);
    end while (hold);
    apply_model(ins);
  endtask

  task automatic idle(input int stall_pct);
    stall      <= ($urandom_range(99, 0) < stall_pct);
    inst_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic finish_run();
    int missing;
    missing = exp_q.size();
    if (missing != 0) begin
      $display("%0d expected register writes were never reported", missing);
    end
    $display("errors: value %0d, missing %0d, unexpected %0d, timeout %0d (%0d reports checked)",
             value_errs, missing, extra_reports, timed_out, reports);
    if (value_errs + missing + extra_reports == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one report checked per strobe, mid cycle
  initial begin
    value_errs    = 0;
    extra_reports = 0;
    reports       = 0;
    forever begin
      @(negedge clk);
      if (!reset && wb.we) begin
        if (exp_q.size() == 0) begin
          extra_reports++;
          $display("unexpected write to x%0d reported with no instruction outstanding", wb.addr);
        end else begin
          check_wb(wb, exp_q.pop_front());
          reports++;
        end
      end
    end
  end

  initial begin
    timed_out = 1'b0;
    for (cycles = 0; cycles < TIMEOUT_CYC; cycles++) @(posedge clk);
    timed_out = 1'b1;
    $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYC);
    finish_run();
  end

  initial begin
    void'($urandom(43));
    for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
    reset      <= 1'b1;
    stall      <= 1'b0;
    inst_valid <= 1'b0;
    inst       <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (5) @(posedge clk);  // quiet pipeline, no reports allowed
    issue(enc_r(7'h00, 5'd3, 5'd2, F3_ADD_SUB, 5'd1), 0);
    issue(enc_r(7'h00, 5'd17, 5'd31, F3_OR, 5'd5), 0);
    issue(enc_i(12'h000, 5'd9, F3_ADD_SUB, 5'd7), 0);
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(enc_lui(20'($urandom), reg_addr_t'(r)), 0);
      issue(enc_i({6'h00, 6'($urandom_range(32, 0))}, reg_addr_t'(r), F3_SLL, reg_addr_t'(r)), 0);
      issue(enc_i(12'($urandom), reg_addr_t'(r), F3_ADD_SUB, reg_addr_t'(r)), 0);
    end
    for (int i = 0; i < N_RAND; i++) issue(rand_op(0, 31), 0);
    for (int i = 0; i < N_RAND; i++) issue(rand_imm(0, 31), 0);
    // tight reuse of x1..x4 hits bypass and write-through
    for (int i = 0; i < N_RAND; i++) begin
      issue(($urandom_range(1, 0) == 1) ? rand_op(1, 4) : rand_imm(1, 4), 0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      while ($urandom_range(3, 0) == 0) idle(30);
      issue(($urandom_range(1, 0) == 1) ? rand_op(1, 7) : rand_imm(1, 7), 30);
    end
    issue(enc_i(12'h7ff, 5'd1, F3_ADD_SUB, 5'd0), 0);      // addi x0
    issue(enc_r(7'h20, 5'd2, 5'd1, F3_ADD_SUB, 5'd0), 0);  // sub x0
    issue({25'($urandom), 7'b0000011}, 0);                 // load opcode
    issue({25'($urandom), 7'b1100011}, 0);                 // branch opcode
    issue(enc_i(12'h000, 5'd0, F3_OR, 5'd5), 0);
    issue(enc_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd6), 0);
    inst_valid <= 1'b0;
    stall      <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== sim/riscv_datapath_asserts.sv ====
`default_nettype none

module riscv_datapath_asserts
  import riscv_pipe_pkg::*;
(
  input logic      i_riscv_datapath_clk,
  input logic      i_reset,
  input logic      i_stall,
  input rf_write_t i_wb
);

  timeunit 1ns;
  timeprecision 1ps;

  // reset cycles plus the first one after release
  a_quiet_reset: assert property (@(posedge i_riscv_datapath_clk)
    $past(i_reset) |-> !i_wb.we)
    else $error("write strobe during reset or in the cycle after it");

  a_no_x0_write: assert property (@(posedge i_riscv_datapath_clk) disable iff (i_reset)
    i_wb.we |-> i_wb.addr != '0)
    else $error("write strobe addressed to x0");

  // stalled report stays hidden and its fields hold
  a_no_write_in_stall: assert property (@(posedge i_riscv_datapath_clk) disable iff (i_reset)
    i_stall |-> !i_wb.we ##1 ($stable(i_wb.addr) && $stable(i_wb.data)))
    else $error("write strobe or report change while the pipeline is stalled");

  a_data_known: assert property (@(posedge i_riscv_datapath_clk) disable iff (i_reset)
    i_wb.we |-> !$isunknown(i_wb.data))
    else $error("write data has unknown bits");

endmodule

`default_nettype wire

// ==== logic/riscv_datapath.sv ====
`default_nettype none

module riscv_datapath
  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;
(
  input  logic      i_riscv_datapath_clk,
  input  logic      i_reset,
  input  logic      i_stall,       // freezes every stage
  input  logic      i_inst_valid,
  input  inst_t     i_inst,
  output rf_write_t o_riscv_datapath_wb
);

  logic        de_valid;
  de_payload_t de;
  logic        ew_valid;
  ew_payload_t ew;
  rf_write_t   wb_write;  // rf write, bypass and report

  riscv_dstage u_riscv_dstage (
    .i_riscv_dstage_clk (i_riscv_datapath_clk),
    .i_reset            (i_reset),
    .i_stall            (i_stall),
    .i_inst_valid       (i_inst_valid),
    .i_inst             (i_inst),
    .i_write            (wb_write),
    .o_valid            (de_valid),
    .o_de               (de)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_estage_clk (i_riscv_datapath_clk),
    .i_reset            (i_reset),
    .i_stall            (i_stall),
    .i_valid            (de_valid),
    .i_de               (de),
    .i_fwd              (wb_write),
    .o_valid            (ew_valid),
    .o_ew               (ew)
  );

  riscv_wbstage u_riscv_wbstage (
    .i_riscv_wbstage_clk (i_riscv_datapath_clk),
    .i_reset             (i_reset),
    .i_stall             (i_stall),
    .i_valid             (ew_valid),
    .i_ew                (ew),
    .o_write             (wb_write)
  );

  assign o_riscv_datapath_wb = wb_write;

endmodule

`default_nettype wire

// ==== logic/riscv_wbstage.sv ====
`default_nettype none

module riscv_wbstage
  import riscv_pipe_pkg::*;
(
  input  logic        i_riscv_wbstage_clk,
  input  logic        i_reset,
  input  logic        i_stall,
  input  logic        i_valid,
  input  ew_payload_t i_ew,
  output rf_write_t   o_write
);

  logic        wb_valid;
  ew_payload_t ew_q;

  always_ff @(posedge i_riscv_wbstage_clk) begin
    if (i_reset) begin
      wb_valid <= 1'b0;
    end else if (!i_stall) begin
      wb_valid <= i_valid;
    end
  end

  always_ff @(posedge i_riscv_wbstage_clk) begin
    if (!i_stall) begin
      ew_q <= i_ew;
    end
  end

  // one strobe per instruction, held off while stalled
  assign o_write.we   = wb_valid && !i_stall;
  assign o_write.addr = ew_q.rd;
  assign o_write.data = ew_q.result;

endmodule

`default_nettype wire

// ==== logic/riscv_estage.sv ====
`default_nettype none

module riscv_estage
  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;
(
  input  logic        i_riscv_estage_clk,
  input  logic        i_reset,
  input  logic        i_stall,
  input  logic        i_valid,
  input  de_payload_t i_de,
  input  rf_write_t   i_fwd,
  output logic        o_valid,
  output ew_payload_t o_ew
);

  logic        de_valid;
  de_payload_t de_q;
  xlen_t       rs1_val;
  xlen_t       rs2_val;
  xlen_t       op_a;
  xlen_t       op_b;
  xlen_t       result;
  logic [SHAMT_W-1:0] shamt;

  riscv_pipe_reg #(.payload_t(de_payload_t)) u_de_reg (
    .i_riscv_pipe_reg_clk (i_riscv_estage_clk),
    .i_reset              (i_reset),
    .i_stall              (i_stall),
    .i_valid              (i_valid),
    .i_data               (i_de),
    .o_valid              (de_valid),
    .o_data               (de_q)
  );

  // writeback result bypass
  assign rs1_val = (i_fwd.we && i_fwd.addr == de_q.rs1_addr && de_q.rs1_addr != '0)
                   ? i_fwd.data : de_q.rs1_data;
  assign rs2_val = (i_fwd.we && i_fwd.addr == de_q.rs2_addr && de_q.rs2_addr != '0)
                   ? i_fwd.data : de_q.rs2_data;

  assign op_a  = rs1_val;
  assign op_b  = de_q.use_imm ? de_q.imm : rs2_val;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (de_q.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;  // keeps sign
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

  assign o_valid = de_valid;
  assign o_ew    = '{rd: de_q.rd, result: result};

endmodule

`default_nettype wire

// ==== logic/riscv_dstage.sv ====
`default_nettype none

module riscv_dstage
  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;
(
  input  logic        i_riscv_dstage_clk,
  input  logic        i_reset,
  input  logic        i_stall,
  input  logic        i_inst_valid,
  input  inst_t       i_inst,
  input  rf_write_t   i_write,
  output logic        o_valid,
  output de_payload_t o_de
);

  logic      fetch_valid;
  fetch_t    fetch_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic      funct7_5;
  reg_addr_t rd;
  reg_addr_t rs1_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     imm;
  logic      use_imm;
  logic      known;
  alu_op_t   alu_op;

  riscv_pipe_reg #(.payload_t(fetch_t)) u_fetch_reg (
    .i_riscv_pipe_reg_clk (i_riscv_dstage_clk),
    .i_reset              (i_reset),
    .i_stall              (i_stall),
    .i_valid              (i_inst_valid),
    .i_data               ('{inst: i_inst}),
    .o_valid              (fetch_valid),
    .o_data               (fetch_q)
  );

  assign opcode   = fetch_q.inst[6:0];
  assign funct3   = fetch_q.inst[14:12];
  assign funct7_5 = fetch_q.inst[30];
  assign rd       = fetch_q.inst[11:7];

  function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    op = ALU_ADD;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    known    = 1'b1;
    use_imm  = 1'b1;
    rs1_addr = fetch_q.inst[19:15];
    alu_op   = ALU_ADD;
    imm      = {{(XLEN-12){fetch_q.inst[31]}}, fetch_q.inst[31:20]};  // i-type
    case (opcode)
      OPC_OP: begin
        use_imm = 1'b0;
        alu_op  = f3_to_alu(funct3, funct7_5);
      end
      OPC_OP_IMM: begin
        alu_op = f3_to_alu(funct3, funct7_5 && funct3 == F3_SRL_SRA);  // addi has no sub
        if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
          imm = {{(XLEN-SHAMT_W){1'b0}}, fetch_q.inst[20 +: SHAMT_W]};
        end
      end
      OPC_LUI: begin
        rs1_addr = '0;  // x0 + imm
        imm      = {{(XLEN-32){fetch_q.inst[31]}}, fetch_q.inst[31:12], 12'b0};
      end
      default: known = 1'b0;
    endcase
  end

  riscv_regfile u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_dstage_clk),
    .i_reset             (i_reset),
    .i_rs1_addr          (rs1_addr),
    .i_rs2_addr          (fetch_q.inst[24:20]),
    .i_write             (i_write),
    .o_rs1_data          (rs1_data),
    .o_rs2_data          (rs2_data)
  );

  // bad opcode or rd == x0 leaves a bubble
  assign o_valid = fetch_valid && known && (rd != '0);
  assign o_de    = '{rs1_addr: rs1_addr, rs2_addr: fetch_q.inst[24:20],
                     rs1_data: rs1_data, rs2_data: rs2_data, imm: imm,
                     use_imm: use_imm, alu_op: alu_op, rd: rd};

endmodule

`default_nettype wire

// ==== logic/riscv_regfile.sv ====
`default_nettype none

module riscv_regfile
  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;
(
  input  logic      i_riscv_regfile_clk,
  input  logic      i_reset,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  rf_write_t i_write,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data
);

  xlen_t regs [1:NUM_REGS-1];  // x0 has no storage

  always_ff @(posedge i_riscv_regfile_clk) begin
    if (i_reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_write.we && i_write.addr != '0) begin
      regs[i_write.addr] <= i_write.data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (i_write.we && i_write.addr == addr) begin
      return i_write.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

endmodule

`default_nettype wire

// ==== logic/riscv_pipe_reg.sv ====
`default_nettype none

module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_riscv_pipe_reg_clk,
  input  logic     i_reset,
  input  logic     i_stall,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_valid,
  output payload_t o_data
);

  always_ff @(posedge i_riscv_pipe_reg_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_valid;
    end
  end

  // payload only moves with the stage
  always_ff @(posedge i_riscv_pipe_reg_clk) begin
    if (!i_stall) begin
      o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/riscv_pipe_pkg.sv ====
`default_nettype none

package riscv_pipe_pkg;

  import riscv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
  } alu_op_t;

  // raw instruction held ahead of decode
  typedef struct packed {
    inst_t inst;
  } fetch_t;

  // decoded op going into execute
  typedef struct packed {
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;       // already sign extended
    logic      use_imm;   // second operand from imm
    alu_op_t   alu_op;
    reg_addr_t rd;
  } de_payload_t;

  typedef struct packed {
    reg_addr_t rd;
    xlen_t     result;
  } ew_payload_t;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    xlen_t     data;
  } rf_write_t;

endpackage

`default_nettype wire

// ==== logic/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

  // datapath sizes
  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SHAMT_W    = 6;   // rv64 shifts use 6 bits

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes handled here
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 of the integer ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;  // funct7[5] picks sra
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire
